// File: Makefile
.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_issue: verilog.f $(wildcard hdl/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_issue \
	  -f verilog.f -Mdir obj_dir -o Vtb_issue

# pass only if the log holds the pass line
run: obj_dir/Vtb_issue
	./obj_dir/Vtb_issue | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/issue_tests.txt
# fu op rs1 rs2 rd imm use_imm use_zimm valid flush flu_rdy lsu_rdy wb0(v id d) wb1(v id d)
# then ack strobe(alu br mult lsu csr) operand_a operand_b stall commit(we addr data), hex
# reset state, then alu with immediate
0 00 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 00 0 0 0 0 0 0
1 13 3 0 1 55 1 0 1 0 1 1 0 0 0 0 0 0 1 10 0 55 0 0 0 0
# read after write, stall then writeback forward then stored result
1 33 1 0 2 0 0 0 1 0 1 1 0 0 0 0 0 0 0 00 0 0 1 0 0 0
1 33 1 0 2 0 0 0 1 0 1 1 1 0 111 0 0 0 1 10 111 0 0 0 0 0
1 33 1 1 3 0 0 0 1 0 1 1 0 0 0 0 0 0 1 10 111 111 0 1 1 111
# write after write, released in the commit cycle
1 13 1 0 2 7 1 0 1 0 1 1 1 1 222 1 2 333 0 00 0 0 0 0 0 0
1 13 1 0 2 7 1 0 1 0 1 1 0 0 0 0 0 0 1 10 111 7 0 1 2 222
0 00 0 0 0 0 0 0 0 0 1 1 1 3 444 0 0 0 0 00 0 0 0 1 3 333
1 33 3 2 4 0 0 0 1 0 1 1 0 0 0 0 0 0 1 10 333 444 0 1 2 444
1 33 2 1 5 0 0 0 1 0 1 1 0 0 0 0 0 0 1 10 444 111 0 0 0 0
# back pressure on alu, load passes, store held
1 13 0 0 6 1 1 0 1 0 0 1 0 0 0 0 0 0 0 00 0 0 0 0 0 0
4 03 1 0 7 10 1 0 1 0 0 1 0 0 0 0 0 0 1 02 111 10 0 0 0 0
5 23 1 2 0 8 1 0 1 0 1 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0
5 23 1 2 0 8 1 0 1 0 1 1 0 0 0 0 0 0 1 02 111 444 0 0 0 0
# full scoreboard
1 13 0 0 8 2 1 0 1 0 1 1 1 0 40 1 1 50 0 00 0 0 0 0 0 0
1 13 0 0 8 2 1 0 1 0 1 1 0 0 0 0 0 0 0 00 0 0 0 1 4 40
1 13 0 0 8 2 1 0 1 0 1 1 1 2 70 1 3 0 1 10 0 2 0 1 5 50
# mult strobe blocks alu for a cycle
3 33 4 5 9 0 0 0 1 0 1 1 0 0 0 0 0 0 1 04 40 50 0 1 7 70
1 13 0 0 a 3 1 0 1 0 1 1 0 0 0 0 0 0 0 00 0 0 0 0 0 0
1 13 0 0 a 3 1 0 1 0 1 1 0 0 0 0 0 0 1 10 0 3 0 0 0 0
# flush, then a former dependent issues at once
1 13 0 0 b 4 1 0 1 1 1 1 0 0 0 0 0 0 0 00 0 0 0 0 0 0
1 33 8 9 a 0 0 0 1 0 1 1 0 0 0 0 0 0 1 10 0 0 0 0 0 0
0 00 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 00 0 0 0 0 0 0

// File: dv/tb_issue.sv
`timescale 1ns/1ps

module tb_issue;

  // one cycle of stimulus
  typedef struct packed {
    issue_pkg::decoder_t                      instr;
    logic                                     valid;
    logic                                     flush;
    logic                                     flu_ready;
    logic                                     lsu_ready;
    issue_pkg::wb_t [issue_pkg::WbPorts-1:0]  wb;
  } stim_t;

  // expected response to that cycle
  typedef struct packed {
    logic        ack;
    // alu, branch, mult, lsu, csr
    logic [4:0]  strobe;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic        stall;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } expect_t;

  logic                                     clock;
  logic                                     reset;
  logic                                     flush;
  issue_pkg::decoder_t                      issue_instr;
  logic                                     issue_valid;
  issue_pkg::wb_t [issue_pkg::WbPorts-1:0]  wb;
  logic                                     flu_ready;
  logic                                     lsu_ready;
  logic                                     issue_ack;
  issue_pkg::fu_data_t                      fu_data;
  logic                                     alu_valid;
  logic                                     branch_valid;
  logic                                     mult_valid;
  logic                                     lsu_valid;
  logic                                     csr_valid;
  logic                                     stall_issue;
  issue_pkg::gpr_write_t                    commit;

  stim_t   stim_q [$];
  expect_t exp_q [$];
  // previous vector whose strobe and bundle show up one edge later
  stim_t   pend_stim;
  expect_t pend_exp;
  // scoreboard slot the next accepted instruction gets
  logic [issue_pkg::TransIdBits-1:0] next_tid;
  logic [issue_pkg::TransIdBits-1:0] pend_tid;
  int      cycle_cnt;
  int      cycle_limit;

  issue_top i_dut (
    .clock          (clock),
    .reset          (reset),
    .flush_i        (flush),
    .issue_instr_i  (issue_instr),
    .issue_valid_i  (issue_valid),
    .wb_i           (wb),
    .flu_ready_i    (flu_ready),
    .lsu_ready_i    (lsu_ready),
    .issue_ack_o    (issue_ack),
    .fu_data_o      (fu_data),
    .alu_valid_o    (alu_valid),
    .branch_valid_o (branch_valid),
    .mult_valid_o   (mult_valid),
    .lsu_valid_o    (lsu_valid),
    .csr_valid_o    (csr_valid),
    .stall_issue_o  (stall_issue),
    .commit_o       (commit)
  );

  // 100 ns period
  always #50 clock = ~clock;

  // run limit
  always @(posedge clock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d clock cycles, vectors did not finish", cycle_limit);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // whole file into the queues
  // lines starting with # are skipped
  task automatic read_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [26];
    stim_t       s;
    expect_t     e;
    fd = $fopen("dv/issue_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file dv/issue_tests.txt");
      $display("test failed");
      $fatal(1, "no vectors");
    end else begin
      while ($fgets(line, fd) != 0) begin
        cnt = $sscanf(line,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
          f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
          f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25]);
        if (cnt == 26) begin
          s.instr.fu       = issue_pkg::fu_t'(f[0][2:0]);
          s.instr.op       = f[1][6:0];
          s.instr.rs1      = f[2][4:0];
          s.instr.rs2      = f[3][4:0];
          s.instr.rd       = f[4][4:0];
          s.instr.imm      = f[5];
          s.instr.use_imm  = f[6][0];
          s.instr.use_zimm = f[7][0];
          s.valid          = f[8][0];
          s.flush          = f[9][0];
          s.flu_ready      = f[10][0];
          s.lsu_ready      = f[11][0];
          s.wb[0].valid    = f[12][0];
          s.wb[0].trans_id = f[13][issue_pkg::TransIdBits-1:0];
          s.wb[0].data     = f[14];
          s.wb[1].valid    = f[15][0];
          s.wb[1].trans_id = f[16][issue_pkg::TransIdBits-1:0];
          s.wb[1].data     = f[17];
          e.ack            = f[18][0];
          e.strobe         = f[19][4:0];
          e.operand_a      = f[20];
          e.operand_b      = f[21];
          e.stall          = f[22][0];
          e.we             = f[23][0];
          e.waddr          = f[24][4:0];
          e.wdata          = f[25];
          stim_q.push_back(s);
          exp_q.push_back(e);
        end else if (cnt > 0) begin
          $display("malformed vector line in dv/issue_tests.txt: %s", line);
          $display("test failed");
          $fatal(1, "bad vector file");
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_inputs(input stim_t s);
    issue_instr = s.instr;
    issue_valid = s.valid;
    flush       = s.flush;
    flu_ready   = s.flu_ready;
    lsu_ready   = s.lsu_ready;
    wb          = s.wb;
  endtask

  // strobes every cycle and the bundle only after an ack
  task automatic verify_dispatch();
    logic [4:0] strobes;
    strobes = {alu_valid, branch_valid, mult_valid, lsu_valid, csr_valid};
    compare_value("valid strobes", {27'b0, strobes}, {27'b0, pend_exp.strobe});
    if (pend_exp.ack) begin
      compare_value("fu_data_o.fu", {29'b0, fu_data.fu}, {29'b0, pend_stim.instr.fu});
      compare_value("fu_data_o.operation", {25'b0, fu_data.operation},
                    {25'b0, pend_stim.instr.op});
      compare_value("fu_data_o.operand_a", fu_data.operand_a, pend_exp.operand_a);
      compare_value("fu_data_o.operand_b", fu_data.operand_b, pend_exp.operand_b);
      compare_value("fu_data_o.imm", fu_data.imm, pend_stim.instr.imm);
      compare_value("fu_data_o.trans_id", {30'b0, fu_data.trans_id}, {30'b0, pend_tid});
    end
  endtask

  // combinational outputs just before the edge
  task automatic inspect_outputs(input expect_t e);
    compare_value("issue_ack_o", {31'b0, issue_ack}, {31'b0, e.ack});
    compare_value("stall_issue_o", {31'b0, stall_issue}, {31'b0, e.stall});
    compare_value("commit_o.we", {31'b0, commit.we}, {31'b0, e.we});
    if (e.we) begin
      compare_value("commit_o.waddr", {27'b0, commit.waddr}, {27'b0, e.waddr});
      compare_value("commit_o.wdata", commit.wdata, e.wdata);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    flush       = 1'b0;
    issue_instr = '0;
    issue_valid = 1'b0;
    wb          = '0;
    flu_ready   = 1'b1;
    lsu_ready   = 1'b1;
    cycle_cnt   = 0;
    cycle_limit = 40;
    pend_stim   = '0;
    pend_exp    = '0;
    next_tid    = '0;
    pend_tid    = '0;
    read_vectors();
    cycle_limit = 2 * stim_q.size() + 40;
    repeat (16) @(posedge clock);
    #10;
    reset = 1'b0;
    for (int n = 0; n < stim_q.size(); n++) begin
      @(posedge clock);
      #5;
      verify_dispatch();
      #5;
      drive_inputs(stim_q[n]);
      #80;
      inspect_outputs(exp_q[n]);
      pend_stim = stim_q[n];
      pend_exp  = exp_q[n];
      pend_tid  = next_tid;
      // slots are handed out in order and a flush starts again at entry 0
      if (stim_q[n].flush) begin
        next_tid = '0;
      end else if (exp_q[n].ack) begin
        next_tid = next_tid + 1'b1;
      end
    end
    // last vector's strobe
    @(posedge clock);
    #5;
    verify_dispatch();
    $display("test passed");
    $finish;
  end

endmodule

// File: hdl/gpr_regfile.sv
`timescale 1ns/1ps

module gpr_regfile (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [4:0]             raddr_1_i,
  input  logic [4:0]             raddr_2_i,
  input  issue_pkg::gpr_write_t  wr_i,
  output logic [31:0]            rdata_1_o,
  output logic [31:0]            rdata_2_o
);

  logic [31:0] mem_q [32];

  // ------------------------------------------------------------------------
  // write port
  // ------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.waddr != 5'd0)) begin
      mem_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // ------------------------------------------------------------------------
  // read ports, asynchronous
  // ------------------------------------------------------------------------
  // x0 hardwired to zero
  assign rdata_1_o = (raddr_1_i == 5'd0) ? '0 : mem_q[raddr_1_i];
  assign rdata_2_o = (raddr_2_i == 5'd0) ? '0 : mem_q[raddr_2_i];

endmodule

// File: hdl/issue_pkg.sv
package issue_pkg;

  // ------------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------------
  // scoreboard entries, a power of two so the pointers wrap freely
  localparam int SbDepth = 4;
  localparam int TransIdBits = 2;
  // result buses coming back from the functional units
  localparam int WbPorts = 2;

  // ------------------------------------------------------------------------
  // functional units
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_CTRL_FLOW,
    FU_MULT,
    FU_LOAD,
    FU_STORE,
    FU_CSR
  } fu_t;

  // decoded instruction waiting at the issue port
  typedef struct packed {
    fu_t         fu;
    logic [6:0]  op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    // rs1 field is a 5 bit immediate (csr*i)
    logic        use_zimm;
  } decoder_t;

  // operand bundle handed to the selected unit
  typedef struct packed {
    fu_t                    fu;
    logic [6:0]             operation;
    logic [31:0]            operand_a;
    logic [31:0]            operand_b;
    logic [31:0]            imm;
    logic [TransIdBits-1:0] trans_id;
  } fu_data_t;

  // one result bus
  typedef struct packed {
    logic                   valid;
    logic [TransIdBits-1:0] trans_id;
    logic [31:0]            data;
  } wb_t;

  // scoreboard entry, also the view the issue stage gets
  typedef struct packed {
    logic        issued;
    logic [4:0]  rd;
    fu_t         fu;
    logic        done;
    logic [31:0] result;
  } sb_entry_t;

  // everything the operand search looks at
  typedef struct packed {
    sb_entry_t [SbDepth-1:0] entry;
    wb_t [WbPorts-1:0]       wb;
  } forwarding_t;

  // register file write, driven by commit
  typedef struct packed {
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } gpr_write_t;

endpackage

// File: hdl/issue_read_operands.sv
`timescale 1ns/1ps

module issue_read_operands (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 flush_i,
  input  issue_pkg::decoder_t                  issue_instr_i,
  input  logic                                 issue_valid_i,
  input  issue_pkg::forwarding_t               fwd_i,
  input  logic [issue_pkg::TransIdBits-1:0]    alloc_id_i,
  input  logic                                 sb_full_i,
  input  issue_pkg::gpr_write_t                commit_i,
  input  logic                                 flu_ready_i,
  input  logic                                 lsu_ready_i,
  input  logic [31:0]                          rdata_1_i,
  input  logic [31:0]                          rdata_2_i,
  output logic [4:0]                           raddr_1_o,
  output logic [4:0]                           raddr_2_o,
  output logic                                 issue_ack_o,
  output issue_pkg::fu_data_t                  fu_data_o,
  output logic                                 alu_valid_o,
  output logic                                 branch_valid_o,
  output logic                                 mult_valid_o,
  output logic                                 lsu_valid_o,
  output logic                                 csr_valid_o,
  output logic                                 stall_issue_o
);

  // one strobe per unit class
  typedef struct packed {
    logic alu;
    logic branch;
    logic mult;
    logic lsu;
    logic csr;
  } fu_valid_t;

  fu_valid_t           valid_n, valid_q;
  issue_pkg::fu_data_t fu_data_n;
  logic [31:0]         clobber;
  logic                fu_busy;
  logic                rs1_clob, rs2_clob;
  logic                rs1_hit, rs2_hit;
  logic [31:0]         rs1_fwd, rs2_fwd;
  logic                stall_raw, stall_waw;

  // ------------------------------------------------------------------------
  // unit busy
  // ------------------------------------------------------------------------
  always_comb begin
    case (issue_instr_i.fu)
      // a mult strobe occupies the fixed latency path for a cycle
      issue_pkg::FU_ALU, issue_pkg::FU_CTRL_FLOW, issue_pkg::FU_CSR:
        fu_busy = !flu_ready_i || mult_valid_o;
      issue_pkg::FU_MULT:
        fu_busy = !flu_ready_i;
      issue_pkg::FU_LOAD, issue_pkg::FU_STORE:
        fu_busy = !lsu_ready_i;
      default:
        fu_busy = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------------
  // clobber map
  // ------------------------------------------------------------------------
  always_comb begin
    clobber = '0;
    for (int i = 0; i < issue_pkg::SbDepth; i++) begin
      if (fwd_i.entry[i].issued) begin
        clobber[fwd_i.entry[i].rd] = 1'b1;
      end
    end
    // x0 never pending
    clobber[0] = 1'b0;
  end

  assign rs1_clob = clobber[issue_instr_i.rs1];
  assign rs2_clob = clobber[issue_instr_i.rs2];

  // ------------------------------------------------------------------------
  // operand search
  // ------------------------------------------------------------------------
  operand_forward u_fwd_rs1 (
    .rs_i   (issue_instr_i.rs1),
    .fwd_i  (fwd_i),
    .hit_o  (rs1_hit),
    .data_o (rs1_fwd)
  );

  operand_forward u_fwd_rs2 (
    .rs_i   (issue_instr_i.rs2),
    .fwd_i  (fwd_i),
    .hit_o  (rs2_hit),
    .data_o (rs2_fwd)
  );

  assign raddr_1_o = issue_instr_i.rs1;
  assign raddr_2_o = issue_instr_i.rs2;

  // pending source without a result yet
  assign stall_raw = (rs1_clob && !rs1_hit) || (rs2_clob && !rs2_hit);
  // rd still owned by an older entry, released by a matching commit
  assign stall_waw = clobber[issue_instr_i.rd]
                  && !(commit_i.we && (commit_i.waddr == issue_instr_i.rd));

  assign stall_issue_o = issue_valid_i && stall_raw;

  assign issue_ack_o = issue_valid_i && !fu_busy && !sb_full_i
                    && !stall_raw && !stall_waw && !flush_i;

  // ------------------------------------------------------------------------
  // operand mux
  // ------------------------------------------------------------------------
  always_comb begin
    fu_data_n.fu        = issue_instr_i.fu;
    fu_data_n.operation = issue_instr_i.op;
    fu_data_n.imm       = issue_instr_i.imm;
    fu_data_n.trans_id  = alloc_id_i;
    fu_data_n.operand_a = rs1_clob ? rs1_fwd : rdata_1_i;
    fu_data_n.operand_b = rs2_clob ? rs2_fwd : rdata_2_i;
    // zimm replaces rs1
    if (issue_instr_i.use_zimm) begin
      fu_data_n.operand_a = {27'b0, issue_instr_i.rs1};
    end
    // stores and branches need rs2, imm goes separately
    if (issue_instr_i.use_imm && (issue_instr_i.fu != issue_pkg::FU_STORE)
        && (issue_instr_i.fu != issue_pkg::FU_CTRL_FLOW)) begin
      fu_data_n.operand_b = issue_instr_i.imm;
    end
  end

  // strobe decode, ack already excludes flush
  always_comb begin
    valid_n = '0;
    if (issue_ack_o) begin
      case (issue_instr_i.fu)
        issue_pkg::FU_ALU:                       valid_n.alu    = 1'b1;
        issue_pkg::FU_CTRL_FLOW:                 valid_n.branch = 1'b1;
        issue_pkg::FU_MULT:                      valid_n.mult   = 1'b1;
        issue_pkg::FU_LOAD, issue_pkg::FU_STORE: valid_n.lsu    = 1'b1;
        issue_pkg::FU_CSR:                       valid_n.csr    = 1'b1;
        default:                                 valid_n        = '0;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // dispatch register
  // ------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_n;
    end
  end

  // bundle only moves on an accepted instruction
  always_ff @(posedge clock) begin
    if (issue_ack_o) begin
      fu_data_o <= fu_data_n;
    end
  end

  assign alu_valid_o    = valid_q.alu;
  assign branch_valid_o = valid_q.branch;
  assign mult_valid_o   = valid_q.mult;
  assign lsu_valid_o    = valid_q.lsu;
  assign csr_valid_o    = valid_q.csr;

  // one unit started per cycle
  assert property (@(posedge clock) disable iff (reset) $onehot0(valid_q))
    else $error("more than one unit strobe");

endmodule

// File: hdl/issue_top.sv
`timescale 1ns/1ps

module issue_top (
  input  logic                                     clock,
  input  logic                                     reset,
  input  logic                                     flush_i,
  input  issue_pkg::decoder_t                      issue_instr_i,
  input  logic                                     issue_valid_i,
  input  issue_pkg::wb_t [issue_pkg::WbPorts-1:0]  wb_i,
  input  logic                                     flu_ready_i,
  input  logic                                     lsu_ready_i,
  output logic                                     issue_ack_o,
  output issue_pkg::fu_data_t                      fu_data_o,
  output logic                                     alu_valid_o,
  output logic                                     branch_valid_o,
  output logic                                     mult_valid_o,
  output logic                                     lsu_valid_o,
  output logic                                     csr_valid_o,
  output logic                                     stall_issue_o,
  output issue_pkg::gpr_write_t                    commit_o
);

  issue_pkg::forwarding_t              fwd;
  issue_pkg::gpr_write_t               commit;
  logic [issue_pkg::TransIdBits-1:0]   alloc_id;
  logic                                sb_full;
  logic                                issue_ack;
  logic [4:0]                          raddr_1, raddr_2;
  logic [31:0]                         rdata_1, rdata_2;

  assign issue_ack_o = issue_ack;
  assign commit_o    = commit;

  // ------------------------------------------------------------------------
  // in-flight tracking
  // ------------------------------------------------------------------------
  scoreboard u_scoreboard (
    .clock         (clock),
    .reset         (reset),
    .flush_i       (flush_i),
    .issue_instr_i (issue_instr_i),
    .issue_ack_i   (issue_ack),
    .wb_i          (wb_i),
    .fwd_o         (fwd),
    .alloc_id_o    (alloc_id),
    .sb_full_o     (sb_full),
    .commit_o      (commit)
  );

  // ------------------------------------------------------------------------
  // hazard check and dispatch
  // ------------------------------------------------------------------------
  issue_read_operands u_issue (
    .clock          (clock),
    .reset          (reset),
    .flush_i        (flush_i),
    .issue_instr_i  (issue_instr_i),
    .issue_valid_i  (issue_valid_i),
    .fwd_i          (fwd),
    .alloc_id_i     (alloc_id),
    .sb_full_i      (sb_full),
    .commit_i       (commit),
    .flu_ready_i    (flu_ready_i),
    .lsu_ready_i    (lsu_ready_i),
    .rdata_1_i      (rdata_1),
    .rdata_2_i      (rdata_2),
    .raddr_1_o      (raddr_1),
    .raddr_2_o      (raddr_2),
    .issue_ack_o    (issue_ack),
    .fu_data_o      (fu_data_o),
    .alu_valid_o    (alu_valid_o),
    .branch_valid_o (branch_valid_o),
    .mult_valid_o   (mult_valid_o),
    .lsu_valid_o    (lsu_valid_o),
    .csr_valid_o    (csr_valid_o),
    .stall_issue_o  (stall_issue_o)
  );

  // architectural state, written by commit only
  gpr_regfile u_regfile (
    .clock     (clock),
    .reset     (reset),
    .raddr_1_i (raddr_1),
    .raddr_2_i (raddr_2),
    .wr_i      (commit),
    .rdata_1_o (rdata_1),
    .rdata_2_o (rdata_2)
  );

endmodule

// File: hdl/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
  input  logic [4:0]              rs_i,
  input  issue_pkg::forwarding_t  fwd_i,
  output logic                    hit_o,
  output logic [31:0]             data_o
);

  localparam int NumSrc = issue_pkg::WbPorts + issue_pkg::SbDepth;

  // candidate requests, lowest index wins
  logic [NumSrc-1:0]       req;
  logic [NumSrc-1:0][31:0] cand;

  // ------------------------------------------------------------------------
  // writeback ports first
  // ------------------------------------------------------------------------
  for (genvar p = 0; p < issue_pkg::WbPorts; p++) begin : gen_wb
    // rd comes from the entry the result belongs to
    assign req[p] = fwd_i.wb[p].valid
                  & fwd_i.entry[fwd_i.wb[p].trans_id].issued
                  & (fwd_i.entry[fwd_i.wb[p].trans_id].rd == rs_i);
    assign cand[p] = fwd_i.wb[p].data;
  end

  // ------------------------------------------------------------------------
  // then finished entries
  // ------------------------------------------------------------------------
  for (genvar e = 0; e < issue_pkg::SbDepth; e++) begin : gen_sb
    assign req[issue_pkg::WbPorts+e] = fwd_i.entry[e].issued
                                     & fwd_i.entry[e].done
                                     & (fwd_i.entry[e].rd == rs_i);
    assign cand[issue_pkg::WbPorts+e] = fwd_i.entry[e].result;
  end

  // fixed priority pick
  always_comb begin
    hit_o  = 1'b0;
    data_o = '0;
    // walk downwards so the lowest requester is left standing
    for (int i = NumSrc - 1; i >= 0; i--) begin
      if (req[i]) begin
        hit_o  = 1'b1;
        data_o = cand[i];
      end
    end
  end

endmodule

// File: hdl/scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic                                           flush_i,
  input  issue_pkg::decoder_t                            issue_instr_i,
  input  logic                                           issue_ack_i,
  input  issue_pkg::wb_t [issue_pkg::WbPorts-1:0]        wb_i,
  output issue_pkg::forwarding_t                         fwd_o,
  output logic [issue_pkg::TransIdBits-1:0]              alloc_id_o,
  output logic                                           sb_full_o,
  output issue_pkg::gpr_write_t                          commit_o
);

  issue_pkg::sb_entry_t                entries_q [issue_pkg::SbDepth];
  issue_pkg::sb_entry_t                head_entry;
  logic [issue_pkg::TransIdBits-1:0]   head_q, tail_q;
  logic [issue_pkg::TransIdBits:0]     count_q;
  logic                                commit_valid;

  // ------------------------------------------------------------------------
  // status out
  // ------------------------------------------------------------------------
  assign alloc_id_o = tail_q;
  assign sb_full_o  = (count_q == issue_pkg::SbDepth);

  for (genvar i = 0; i < issue_pkg::SbDepth; i++) begin : gen_fwd
    assign fwd_o.entry[i] = entries_q[i];
  end
  assign fwd_o.wb = wb_i;

  // ------------------------------------------------------------------------
  // commit
  // ------------------------------------------------------------------------
  assign head_entry   = entries_q[head_q];
  assign commit_valid = head_entry.issued && head_entry.done;

  // x0 retires without a write
  assign commit_o.we    = commit_valid && (head_entry.rd != 5'd0);
  assign commit_o.waddr = head_entry.rd;
  assign commit_o.wdata = head_entry.result;

  // ------------------------------------------------------------------------
  // entry state
  // ------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < issue_pkg::SbDepth; i++) begin
        entries_q[i].issued <= 1'b0;
        entries_q[i].done   <= 1'b0;
      end
    end else begin
      // allocate at tail
      if (issue_ack_i) begin
        entries_q[tail_q].issued <= 1'b1;
        entries_q[tail_q].done   <= 1'b0;
        entries_q[tail_q].rd     <= issue_instr_i.rd;
        entries_q[tail_q].fu     <= issue_instr_i.fu;
        tail_q                   <= tail_q + 1'b1;
      end
      // capture results
      for (int p = 0; p < issue_pkg::WbPorts; p++) begin
        if (wb_i[p].valid) begin
          entries_q[wb_i[p].trans_id].done   <= 1'b1;
          entries_q[wb_i[p].trans_id].result <= wb_i[p].data;
        end
      end
      // retire head, never the slot just allocated since ack needs room
      if (commit_valid) begin
        entries_q[head_q].issued <= 1'b0;
        entries_q[head_q].done   <= 1'b0;
        head_q                   <= head_q + 1'b1;
      end
      case ({issue_ack_i, commit_valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  for (genvar p = 0; p < issue_pkg::WbPorts; p++) begin : gen_wb_chk
    assert property (@(posedge clock) disable iff (reset || flush_i)
      wb_i[p].valid |-> entries_q[wb_i[p].trans_id].issued)
      else $error("writeback to a free scoreboard entry");
  end

  // the issue stage must see full before it acks
  assert property (@(posedge clock) disable iff (reset) issue_ack_i |-> !sb_full_o)
    else $error("issue acknowledged into a full scoreboard");

endmodule

// File: verilog.f
hdl/issue_pkg.sv
hdl/gpr_regfile.sv
hdl/operand_forward.sv
hdl/issue_read_operands.sv
hdl/scoreboard.sv
hdl/issue_top.sv
dv/tb_issue.sv
